// ==== Bender.yml ====
package:
  name: issue_top

export_include_dirs:
  - logic

sources:
  - files:
      - logic/sched_types_pkg.sv
      - logic/sched_apb_pkg.sv
      - logic/rob_table.sv
      - logic/oldest_ready_picker.sv
      - logic/issue_combiner.sv
      - logic/issue_top.sv
  - target: test
    files:
      - verification/issue_top_properties.sv
      - verification/issue_top_tb.sv

// ==== issue_top.f ====
+incdir+logic
logic/sched_types_pkg.sv
logic/sched_apb_pkg.sv
logic/rob_table.sv
logic/oldest_ready_picker.sv
logic/issue_combiner.sv
logic/issue_top.sv
verification/issue_top_properties.sv
verification/issue_top_tb.sv

// ==== logic/issue_combiner.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module issue_combiner (
	input  logic                             clk,
	input  logic                             rst,
	input  sched_types_pkg::alu_grant_t [1:0] alu_pick_i,
	input  sched_types_pkg::mem_grant_t      mem_pick_i,
	input  sched_types_pkg::rob_mask_t       stomp_pulse_i,
	output sched_types_pkg::alu_grant_t      alu0_grant_o,
	output sched_types_pkg::alu_grant_t      alu1_grant_o,
	output sched_types_pkg::mem_grant_t      agen_grant_o,
	output sched_types_pkg::rob_mask_t       issued_mask_o,
	output sched_types_pkg::issue_count_t    issue_count_o
);

	import sched_types_pkg::*;

	alu_grant_t [1:0] alu_keep;
	mem_grant_t       mem_keep;
	logic [1:0]       grant_cnt;
	issue_count_t     issue_count_q;

	// ==============================
	// Stomp filter
	// ==============================

	always_comb begin
		alu_keep = alu_pick_i;
		mem_keep = mem_pick_i;
		issued_mask_o = '0;
		for (int k = 0; k < 2; k++) begin
			if (stomp_pulse_i[alu_keep[k].ndx])
				alu_keep[k].valid = 1'b0;
			if (alu_keep[k].valid)
				issued_mask_o[alu_keep[k].ndx] = 1'b1;
		end
		if (stomp_pulse_i[mem_keep.ndx])
			mem_keep.valid = 1'b0;
		if (mem_keep.valid)
			issued_mask_o[mem_keep.ndx] = 1'b1;
		// At most three grants per cycle
		grant_cnt = {1'b0, alu_keep[0].valid} + {1'b0, alu_keep[1].valid} + {1'b0, mem_keep.valid};
	end

	// ==============================
	// Grant registers
	// ==============================

	// The table sets out on the same edge, so each grant is a single cycle pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			alu0_grant_o.valid <= 1'b0;
			alu1_grant_o.valid <= 1'b0;
			agen_grant_o.valid <= 1'b0;
			issue_count_q      <= '0;
		end else begin
			alu0_grant_o  <= alu_keep[0];
			alu1_grant_o  <= alu_keep[1];
			agen_grant_o  <= mem_keep;
			issue_count_q <= issue_count_q + issue_count_t'(grant_cnt);
		end
	end

	assign issue_count_o = issue_count_q;

endmodule

// ==== logic/issue_top.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module issue_top (
	input  logic                          clk,
	input  logic                          rst,
	input  sched_apb_pkg::apb_req_t       apb_req_i,
	output sched_apb_pkg::apb_rsp_t       apb_rsp_o,
	input  logic                          alu0_idle_i,
	input  logic                          alu1_idle_i,
	input  logic                          agen_idle_i,
	output sched_types_pkg::alu_grant_t   alu0_grant_o,
	output sched_types_pkg::alu_grant_t   alu1_grant_o,
	output sched_types_pkg::mem_grant_t   agen_grant_o,
	output sched_types_pkg::issue_count_t issue_count_o
);

	import sched_types_pkg::*;

	rob_ndx_t  head;
	rob_mask_t alu_eligible;
	rob_mask_t mem_pending;
	rob_mask_t mem_ready;
	rob_mask_t stomp_pulse;
	rob_mask_t issued_mask;
	alu_payload_t [`SCHED_ENTRIES-1:0] alu_payload;
	mem_payload_t [`SCHED_ENTRIES-1:0] mem_payload;
	alu_grant_t [1:0] alu_picks;
	mem_grant_t       mem_pick;

	// ==============================
	// Window storage
	// ==============================

	rob_table u_rob_table (
		.clk            (clk),
		.rst            (rst),
		.apb_req_i      (apb_req_i),
		.apb_rsp_o      (apb_rsp_o),
		.issued_mask_i  (issued_mask),
		.head_o         (head),
		.alu_eligible_o (alu_eligible),
		.mem_pending_o  (mem_pending),
		.mem_ready_o    (mem_ready),
		.alu_payload_o  (alu_payload),
		.mem_payload_o  (mem_payload),
		.stomp_pulse_o  (stomp_pulse)
	);

	// ==============================
	// Pickers
	// ==============================

	// Two ALUs, any order among ready entries, oldest first
	oldest_ready_picker #(
		.payload_t (alu_payload_t),
		.NUM_PICKS (2),
		.IN_ORDER  (1'b0)
	) u_alu_picker (
		.head_i      (head),
		.candidate_i (alu_eligible),
		.ready_i     (mem_ready),
		.payload_i   (alu_payload),
		.idle_i      ({alu1_idle_i, alu0_idle_i}),
		.pick_o      (alu_picks)
	);

	// One address generator, strictly in program order
	oldest_ready_picker #(
		.payload_t (mem_payload_t),
		.NUM_PICKS (1),
		.IN_ORDER  (1'b1)
	) u_mem_picker (
		.head_i      (head),
		.candidate_i (mem_pending),
		.ready_i     (mem_ready),
		.payload_i   (mem_payload),
		.idle_i      (agen_idle_i),
		.pick_o      (mem_pick)
	);

	issue_combiner u_issue_combiner (
		.clk           (clk),
		.rst           (rst),
		.alu_pick_i    (alu_picks),
		.mem_pick_i    (mem_pick),
		.stomp_pulse_i (stomp_pulse),
		.alu0_grant_o  (alu0_grant_o),
		.alu1_grant_o  (alu1_grant_o),
		.agen_grant_o  (agen_grant_o),
		.issued_mask_o (issued_mask),
		.issue_count_o (issue_count_o)
	);

endmodule

// ==== logic/oldest_ready_picker.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module oldest_ready_picker #(
	parameter type payload_t = logic [`SCHED_PAYLOAD_W-1:0],
	parameter int  NUM_PICKS = 1,
	parameter bit  IN_ORDER  = 1'b0
) (
	input  sched_types_pkg::rob_ndx_t   head_i,
	input  sched_types_pkg::rob_mask_t  candidate_i,
	input  sched_types_pkg::rob_mask_t  ready_i,
	input  payload_t [`SCHED_ENTRIES-1:0] payload_i,
	input  logic [NUM_PICKS-1:0]        idle_i,
	output logic [NUM_PICKS-1:0][$bits(payload_t)+$bits(sched_types_pkg::rob_ndx_t):0] pick_o
);

	import sched_types_pkg::*;

	// Same field order as the grant types of the package
	typedef struct packed {
		logic     valid;
		rob_ndx_t ndx;
		payload_t payload;
	} pick_t;

	pick_t [NUM_PICKS-1:0] picks;

	// ==============================
	// Age ordered scan
	// ==============================

	// Walk the window from the head, so the first hit is always the oldest
	// Slot k is tied to the k-th ready candidate found, a busy unit leaves
	// its candidate waiting in the table for a later cycle
	always_comb begin
		int       found;
		logic     stop;
		rob_ndx_t ndx;

		picks = '0;
		found = 0;
		stop  = 1'b0;
		for (int a = 0; a < `SCHED_ENTRIES; a++) begin
			ndx = head_i + rob_ndx_t'(a);
			if (candidate_i[ndx] && !stop) begin
				// In program order only the oldest candidate may go, ready or not
				if (IN_ORDER)
					stop = 1'b1;
				if (ready_i[ndx]) begin
					for (int k = 0; k < NUM_PICKS; k++) begin
						if (k == found && idle_i[k]) begin
							picks[k].valid   = 1'b1;
							picks[k].ndx     = ndx;
							picks[k].payload = payload_i[ndx];
						end
					end
					found = found + 1;
				end
			end
		end
	end

	assign pick_o = picks;

endmodule

// ==== logic/rob_table.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module rob_table (
	input  logic                                              clk,
	input  logic                                              rst,
	input  sched_apb_pkg::apb_req_t                           apb_req_i,
	output sched_apb_pkg::apb_rsp_t                           apb_rsp_o,
	input  sched_types_pkg::rob_mask_t                        issued_mask_i,
	output sched_types_pkg::rob_ndx_t                         head_o,
	output sched_types_pkg::rob_mask_t                        alu_eligible_o,
	output sched_types_pkg::rob_mask_t                        mem_pending_o,
	output sched_types_pkg::rob_mask_t                        mem_ready_o,
	output sched_types_pkg::alu_payload_t [`SCHED_ENTRIES-1:0] alu_payload_o,
	output sched_types_pkg::mem_payload_t [`SCHED_ENTRIES-1:0] mem_payload_o,
	output sched_types_pkg::rob_mask_t                        stomp_pulse_o
);

	import sched_types_pkg::*;

	localparam int NDX_W = $bits(rob_ndx_t);
	// First byte address past the entry registers
	localparam logic [`SCHED_APB_ADDR_W-1:0] ENTRY_SPAN = `SCHED_ENTRIES * 4;

	sched_entries_t entries_q;
	rob_ndx_t       head_q;

	logic     acc;
	logic     entry_sel;
	logic     entry_wr;
	logic     head_wr;
	logic     stomp_wr;
	rob_ndx_t reg_ndx;
	rob_ndx_t new_head;
	rob_ndx_t [`SCHED_ENTRIES-1:0] age;
	rob_mask_t retire;
	rob_mask_t blocked;

	// ==============================
	// APB decode
	// ==============================

	// A transfer completes in its access phase since pready is tied high
	assign acc       = apb_req_i.psel && apb_req_i.penable;
	assign entry_sel = (apb_req_i.paddr < ENTRY_SPAN) && (apb_req_i.paddr[1:0] == 2'b00);
	assign reg_ndx   = apb_req_i.paddr[2 +: NDX_W];
	assign new_head  = apb_req_i.pwdata[NDX_W-1:0];

	assign entry_wr = acc && apb_req_i.pwrite && entry_sel;
	assign head_wr  = acc && apb_req_i.pwrite && (apb_req_i.paddr == `SCHED_HEAD_ADDR);
	assign stomp_wr = acc && apb_req_i.pwrite && (apb_req_i.paddr == `SCHED_STOMP_ADDR);

	// The stomp mask is shown to the combiner in the same cycle it lands here,
	// so a pick of a stomped entry made in that cycle never reaches a unit
	assign stomp_pulse_o = stomp_wr ? apb_req_i.pwdata[`SCHED_ENTRIES-1:0] : '0;

	always_comb begin
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = 1'b0;
		apb_rsp_o.prdata  = '0;
		if (entry_sel) begin
			apb_rsp_o.prdata[`SCHED_F_PAYLOAD_LSB +: `SCHED_PAYLOAD_W] = entries_q[reg_ndx].payload;
			apb_rsp_o.prdata[`SCHED_F_CLASS_LSB +: 2] = entries_q[reg_ndx].cls;
			apb_rsp_o.prdata[`SCHED_F_SRC_A] = entries_q[reg_ndx].src_a_ready;
			apb_rsp_o.prdata[`SCHED_F_SRC_B] = entries_q[reg_ndx].src_b_ready;
			apb_rsp_o.prdata[`SCHED_F_VALID] = entries_q[reg_ndx].valid;
			apb_rsp_o.prdata[`SCHED_F_OUT]   = entries_q[reg_ndx].out;
		end else if (apb_req_i.paddr == `SCHED_HEAD_ADDR) begin
			apb_rsp_o.prdata[NDX_W-1:0] = head_q;
		end
	end

	// ==============================
	// Age, retire and barrier
	// ==============================

	always_comb begin
		for (int i = 0; i < `SCHED_ENTRIES; i++) begin
			// Distance from the head, the head itself is the oldest with age 0
			age[i] = rob_ndx_t'(i) - head_q;
			// Everything from the old head up to but not including the new head retires
			retire[i] = age[i] < rob_ndx_t'(new_head - head_q);
		end
		for (int i = 0; i < `SCHED_ENTRIES; i++) begin
			blocked[i] = 1'b0;
			for (int j = 0; j < `SCHED_ENTRIES; j++) begin
				// Any older valid SYNC holds back all younger work
				if (entries_q[j].valid && entries_q[j].cls == CLS_SYNC && age[j] < age[i])
					blocked[i] = 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `SCHED_ENTRIES; i++) begin
			// Source readiness alone, valid for any class
			mem_ready_o[i] = entries_q[i].src_a_ready && entries_q[i].src_b_ready;
			alu_eligible_o[i] = entries_q[i].valid && entries_q[i].cls == CLS_ALU &&
				mem_ready_o[i] && !entries_q[i].out && !blocked[i];
			// Readiness left out here so the in-order picker sees an unready oldest
			mem_pending_o[i] = entries_q[i].valid && entries_q[i].cls == CLS_MEM &&
				!entries_q[i].out && !blocked[i];
			alu_payload_o[i] = alu_payload_t'(entries_q[i].payload);
			mem_payload_o[i] = mem_payload_t'(entries_q[i].payload);
		end
	end

	assign head_o = head_q;

	// ==============================
	// Entry and head state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			for (int i = 0; i < `SCHED_ENTRIES; i++) begin
				entries_q[i].valid <= 1'b0;
				entries_q[i].out   <= 1'b0;
			end
		end else begin
			// Issue marks first, a host write to the same entry overrides them
			for (int i = 0; i < `SCHED_ENTRIES; i++) begin
				if (issued_mask_i[i])
					entries_q[i].out <= 1'b1;
			end
			if (entry_wr) begin
				entries_q[reg_ndx].payload     <= apb_req_i.pwdata[`SCHED_F_PAYLOAD_LSB +: `SCHED_PAYLOAD_W];
				entries_q[reg_ndx].cls         <= entry_class_e'(apb_req_i.pwdata[`SCHED_F_CLASS_LSB +: 2]);
				entries_q[reg_ndx].src_a_ready <= apb_req_i.pwdata[`SCHED_F_SRC_A];
				entries_q[reg_ndx].src_b_ready <= apb_req_i.pwdata[`SCHED_F_SRC_B];
				entries_q[reg_ndx].valid       <= apb_req_i.pwdata[`SCHED_F_VALID];
				entries_q[reg_ndx].out         <= 1'b0;
			end
			if (head_wr) begin
				head_q <= new_head;
				for (int i = 0; i < `SCHED_ENTRIES; i++) begin
					if (retire[i]) begin
						entries_q[i].valid <= 1'b0;
						entries_q[i].out   <= 1'b0;
					end
				end
			end
			if (stomp_wr) begin
				for (int i = 0; i < `SCHED_ENTRIES; i++) begin
					if (stomp_pulse_o[i])
						entries_q[i].valid <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== logic/sched_apb_pkg.sv ====
`include "sched_settings.svh"

package sched_apb_pkg;

	// ==============================
	// APB3 style bus types
	// ==============================

	typedef logic [`SCHED_APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [`SCHED_APB_DATA_W-1:0] apb_data_t;

	// Host to slave, setup phase is psel alone, access phase adds penable
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// Slave to host
	// This slave never stretches a transfer and never flags an error
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

endpackage

// ==== logic/sched_settings.svh ====
`ifndef SCHED_SETTINGS_SVH
`define SCHED_SETTINGS_SVH

// ==============================
// Window geometry
// ==============================

// Number of reorder window entries, must be a power of two
`define SCHED_ENTRIES 8
// Width of the per-entry payload carried to the execution units
`define SCHED_PAYLOAD_W 8

// ==============================
// APB register map
// ==============================

`define SCHED_APB_ADDR_W 8
`define SCHED_APB_DATA_W 32

// Entry n sits at byte address n*4, the control registers follow the entries
`define SCHED_HEAD_ADDR 8'h40
`define SCHED_STOMP_ADDR 8'h44

// Bit layout of an entry register, out is read only and cleared by any write
`define SCHED_F_PAYLOAD_LSB 0
`define SCHED_F_CLASS_LSB 8
`define SCHED_F_SRC_A 10
`define SCHED_F_SRC_B 11
`define SCHED_F_VALID 12
`define SCHED_F_OUT 13

`endif

// ==== logic/sched_types_pkg.sv ====
`include "sched_settings.svh"

package sched_types_pkg;

	// ==============================
	// Window indexing
	// ==============================

	// Index into the window, wraps naturally at the window size
	typedef logic [$clog2(`SCHED_ENTRIES)-1:0] rob_ndx_t;
	// One bit per window entry
	typedef logic [`SCHED_ENTRIES-1:0] rob_mask_t;
	// Running count of grants handed to the units
	typedef logic [15:0] issue_count_t;

	// Functional class of an entry, SYNC never issues and acts as a barrier
	typedef enum logic [1:0] {
		CLS_NONE = 2'd0,
		CLS_ALU  = 2'd1,
		CLS_MEM  = 2'd2,
		CLS_SYNC = 2'd3
	} entry_class_e;

	// ==============================
	// Payloads
	// ==============================

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] dest;
	} alu_payload_t;

	typedef struct packed {
		logic       store;
		logic [1:0] size;
		logic [4:0] base;
	} mem_payload_t;

	// Stored part of a window entry
	// The age of an entry is not kept here, the table derives it from the head
	typedef struct packed {
		logic                         valid;
		entry_class_e                 cls;
		logic                         src_a_ready;
		logic                         src_b_ready;
		logic                         out;
		logic [`SCHED_PAYLOAD_W-1:0]  payload;
	} rob_entry_t;

	typedef rob_entry_t [`SCHED_ENTRIES-1:0] sched_entries_t;

	// ==============================
	// Unit grants
	// ==============================

	// Field order matters, the picker builds the same layout from its own type
	typedef struct packed {
		logic         valid;
		rob_ndx_t     ndx;
		alu_payload_t payload;
	} alu_grant_t;

	typedef struct packed {
		logic         valid;
		rob_ndx_t     ndx;
		mem_payload_t payload;
	} mem_grant_t;

endpackage

// ==== verification/issue_top_properties.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module issue_top_properties (
	input logic                        clk,
	input logic                        rst,
	input sched_apb_pkg::apb_req_t     apb_req_i,
	input sched_types_pkg::alu_grant_t alu0_grant_i,
	input sched_types_pkg::alu_grant_t alu1_grant_i,
	input sched_types_pkg::mem_grant_t agen_grant_i
);

	import sched_types_pkg::*;

	int        fail_count = 0;
	rob_mask_t granted_q;
	logic      entry_wr;
	rob_ndx_t  wr_ndx;

	assign entry_wr = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite &&
		(apb_req_i.paddr < `SCHED_ENTRIES * 4) && (apb_req_i.paddr[1:0] == 2'b00);
	assign wr_ndx = apb_req_i.paddr[2 +: $bits(rob_ndx_t)];

	// ==============================
	// Grant history per entry
	// ==============================

	// A rewrite of the entry rearms it, a seen grant marks it spent
	always_ff @(posedge clk) begin
		if (rst) begin
			granted_q <= '0;
		end else begin
			for (int i = 0; i < `SCHED_ENTRIES; i++) begin
				if (entry_wr && wr_ndx == rob_ndx_t'(i))
					granted_q[i] <= 1'b0;
				else if ((alu0_grant_i.valid && alu0_grant_i.ndx == rob_ndx_t'(i)) ||
					(alu1_grant_i.valid && alu1_grant_i.ndx == rob_ndx_t'(i)) ||
					(agen_grant_i.valid && agen_grant_i.ndx == rob_ndx_t'(i)))
					granted_q[i] <= 1'b1;
			end
		end
	end

	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !(alu0_grant_i.valid || alu1_grant_i.valid || agen_grant_i.valid))
		else begin
			fail_count++;
			$error("grant valid during or right after reset");
		end

	a_alu_distinct: assert property (@(posedge clk) disable iff (rst)
		alu0_grant_i.valid && alu1_grant_i.valid |-> alu0_grant_i.ndx != alu1_grant_i.ndx)
		else begin
			fail_count++;
			$error("both ALUs granted the same entry");
		end

	a_alu0_once: assert property (@(posedge clk) disable iff (rst)
		alu0_grant_i.valid |-> !granted_q[alu0_grant_i.ndx])
		else begin
			fail_count++;
			$error("alu0 regranted an entry that was not rewritten");
		end

	a_alu1_once: assert property (@(posedge clk) disable iff (rst)
		alu1_grant_i.valid |-> !granted_q[alu1_grant_i.ndx])
		else begin
			fail_count++;
			$error("alu1 regranted an entry that was not rewritten");
		end

	a_agen_once: assert property (@(posedge clk) disable iff (rst)
		agen_grant_i.valid |-> !granted_q[agen_grant_i.ndx])
		else begin
			fail_count++;
			$error("agen regranted an entry that was not rewritten");
		end

endmodule

bind issue_top issue_top_properties u_properties (
	.clk          (clk),
	.rst          (rst),
	.apb_req_i    (apb_req_i),
	.alu0_grant_i (alu0_grant_o),
	.alu1_grant_i (alu1_grant_o),
	.agen_grant_i (agen_grant_o)
);

// ==== verification/issue_top_tb.sv ====
`timescale 1ns/1ps
`include "sched_settings.svh"

module issue_top_tb;

	import sched_types_pkg::*;
	import sched_apb_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int DRIVE = 1;
	localparam int NUM_TESTS = 5;
	// Rising edges from the write edge to the edge that first samples the grant
	localparam int GRANT_LAT = 2;
	localparam logic [1:0] UNIT_ALU0 = 2'd0;
	localparam logic [1:0] UNIT_ALU1 = 2'd1;
	localparam logic [1:0] UNIT_AGEN = 2'd2;

	// One observed grant, stamped with the falling edge count
	typedef struct packed {
		logic [1:0]                  unit;
		rob_ndx_t                    ndx;
		logic [`SCHED_PAYLOAD_W-1:0] payload;
		logic [31:0]                 stamp;
	} grant_rec_t;

	logic         clk = 1'b0;
	logic         rst;
	apb_req_t     apb_req;
	apb_rsp_t     apb_rsp;
	logic         alu0_idle;
	logic         alu1_idle;
	logic         agen_idle;
	alu_grant_t   alu0_grant;
	alu_grant_t   alu1_grant;
	mem_grant_t   agen_grant;
	issue_count_t issue_count;

	logic [15:0] lfsr;
	rob_ndx_t    head_model;
	grant_rec_t  grant_log[$];
	int          neg_cnt = 0;
	int          n_checks;
	int          n_errors;

	issue_top u_dut (
		.clk           (clk),
		.rst           (rst),
		.apb_req_i     (apb_req),
		.apb_rsp_o     (apb_rsp),
		.alu0_idle_i   (alu0_idle),
		.alu1_idle_i   (alu1_idle),
		.agen_idle_i   (agen_idle),
		.alu0_grant_o  (alu0_grant),
		.alu1_grant_o  (alu1_grant),
		.agen_grant_o  (agen_grant),
		.issue_count_o (issue_count)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==============================
	// Helpers
	// ==============================

	function automatic grant_rec_t make_rec(input logic [1:0] unit, input rob_ndx_t ndx,
		input logic [`SCHED_PAYLOAD_W-1:0] payload, input int stamp);
		grant_rec_t rec;
		rec.unit    = unit;
		rec.ndx     = ndx;
		rec.payload = payload;
		rec.stamp   = stamp;
		return rec;
	endfunction

	// Grants are registered, so the falling edge always sees them settled
	always @(negedge clk) begin
		neg_cnt = neg_cnt + 1;
		if (rst === 1'b0) begin
			if (alu0_grant.valid)
				grant_log.push_back(make_rec(UNIT_ALU0, alu0_grant.ndx, alu0_grant.payload, neg_cnt));
			if (alu1_grant.valid)
				grant_log.push_back(make_rec(UNIT_ALU1, alu1_grant.ndx, alu1_grant.payload, neg_cnt));
			if (agen_grant.valid)
				grant_log.push_back(make_rec(UNIT_AGEN, agen_grant.ndx, agen_grant.payload, neg_cnt));
		end
	end

	// Taps 16, 14, 13 and 11 give a maximal length sequence
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [7:0] entry_addr(input rob_ndx_t ndx);
		return 8'(ndx) << 2;
	endfunction

	// Entry register image built from the register map
	function automatic logic [31:0] entry_word(input logic valid, input logic [1:0] cls,
		input logic src_a, input logic src_b, input logic [`SCHED_PAYLOAD_W-1:0] payload);
		logic [31:0] w;
		w = '0;
		w[`SCHED_F_PAYLOAD_LSB +: `SCHED_PAYLOAD_W] = payload;
		w[`SCHED_F_CLASS_LSB +: 2] = cls;
		w[`SCHED_F_SRC_A] = src_a;
		w[`SCHED_F_SRC_B] = src_b;
		w[`SCHED_F_VALID] = valid;
		return w;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
		end
	endtask

	task automatic set_idle(input logic v);
		alu0_idle = v;
		alu1_idle = v;
		agen_idle = v;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#DRIVE;
		end
	endtask

	// ==============================
	// APB host
	// ==============================

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input bit wake_units);
		@(posedge clk);
		#DRIVE;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(posedge clk);
		#DRIVE;
		apb_req.penable = 1'b1;
		// Waking the units here lines their picks up with the access cycle
		if (wake_units)
			set_idle(1'b1);
		@(posedge clk);
		#DRIVE;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk);
		#DRIVE;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr;
		apb_req.pwdata  = '0;
		@(posedge clk);
		#DRIVE;
		apb_req.penable = 1'b1;
		@(negedge clk);
		data = apb_rsp.prdata;
		check("apb_rsp_o.pready", 1, apb_rsp.pready);
		check("apb_rsp_o.pslverr", 0, apb_rsp.pslverr);
		@(posedge clk);
		#DRIVE;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic clear_window();
		set_idle(1'b1);
		for (int i = 0; i < `SCHED_ENTRIES; i++)
			apb_write(entry_addr(rob_ndx_t'(i)), 32'h0, 1'b0);
		idle_cycles(2);
		grant_log.delete();
	endtask

	task automatic wait_grants(input int count, input int max_cycles);
		int waited;
		waited = 0;
		while (grant_log.size() < count && waited < max_cycles) begin
			@(posedge clk);
			#DRIVE;
			waited++;
		end
		if (grant_log.size() < count) begin
			n_errors++;
			$display("missing grants: expected %0d within %0d cycles but saw only %0d",
				count, max_cycles, grant_log.size());
		end
	endtask

	task automatic expect_grant(input int pos, input logic [1:0] unit, input rob_ndx_t ndx,
		input logic [`SCHED_PAYLOAD_W-1:0] payload, input int stamp);
		grant_rec_t rec;
		if (pos >= grant_log.size()) begin
			n_errors++;
			$display("grant number %0d was expected but never appeared", pos);
		end else begin
			rec = grant_log[pos];
			check($sformatf("grant %0d unit", pos), unit, rec.unit);
			check($sformatf("grant %0d ndx", pos), ndx, rec.ndx);
			check($sformatf("grant %0d payload", pos), payload, rec.payload);
			check($sformatf("grant %0d cycle", pos), stamp, rec.stamp);
		end
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_single_alu();
		rob_ndx_t     ndx;
		logic [31:0]  pl;
		logic [31:0]  rd;
		int           t_wr;
		issue_count_t cnt0;
		clear_window();
		ndx  = head_model + 3'd2;
		take_bits(`SCHED_PAYLOAD_W, pl);
		cnt0 = issue_count;
		apb_write(entry_addr(ndx), entry_word(1'b1, CLS_ALU, 1'b1, 1'b1, pl[7:0]), 1'b0);
		t_wr = neg_cnt;
		wait_grants(1, 20);
		expect_grant(0, UNIT_ALU0, ndx, pl[7:0], t_wr + GRANT_LAT);
		idle_cycles(4);
		// Out is set on the grant edge, so exactly one pulse
		check("grant pulses", 1, grant_log.size());
		check("issue_count_o", cnt0 + 1, issue_count);
		apb_read(entry_addr(ndx), rd);
		check("entry out bit", 1, rd[`SCHED_F_OUT]);
	endtask

	task automatic test_oldest_first();
		logic [31:0]  pl[3];
		int           t_wr;
		issue_count_t cnt0;
		clear_window();
		cnt0 = issue_count;
		// Busy ALUs let all three entries gather before any pick
		set_idle(1'b0);
		for (int k = 0; k < 3; k++) begin
			take_bits(`SCHED_PAYLOAD_W, pl[k]);
			apb_write(entry_addr(head_model + rob_ndx_t'(k)),
				entry_word(1'b1, CLS_ALU, 1'b1, 1'b1, pl[k][7:0]), 1'b0);
		end
		set_idle(1'b1);
		t_wr = neg_cnt;
		wait_grants(3, 20);
		expect_grant(0, UNIT_ALU0, head_model, pl[0][7:0], t_wr + GRANT_LAT);
		expect_grant(1, UNIT_ALU1, head_model + 3'd1, pl[1][7:0], t_wr + GRANT_LAT);
		expect_grant(2, UNIT_ALU0, head_model + 3'd2, pl[2][7:0], t_wr + GRANT_LAT + 1);
		idle_cycles(3);
		check("grant pulses", 3, grant_log.size());
		check("issue_count_o", cnt0 + 3, issue_count);
	endtask

	task automatic test_mem_in_order();
		logic [31:0]  pl_old;
		logic [31:0]  pl_young;
		int           t_rel;
		issue_count_t cnt0;
		clear_window();
		cnt0 = issue_count;
		take_bits(`SCHED_PAYLOAD_W, pl_old);
		take_bits(`SCHED_PAYLOAD_W, pl_young);
		// Older access still waits on a source while the younger one is ready
		apb_write(entry_addr(head_model), entry_word(1'b1, CLS_MEM, 1'b0, 1'b1, pl_old[7:0]), 1'b0);
		apb_write(entry_addr(head_model + 3'd1),
			entry_word(1'b1, CLS_MEM, 1'b1, 1'b1, pl_young[7:0]), 1'b0);
		idle_cycles(6);
		check("grants past an unready older access", 0, grant_log.size());
		agen_idle = 1'b0;
		apb_write(entry_addr(head_model), entry_word(1'b1, CLS_MEM, 1'b1, 1'b1, pl_old[7:0]), 1'b0);
		idle_cycles(6);
		check("grants while agen busy", 0, grant_log.size());
		agen_idle = 1'b1;
		t_rel = neg_cnt;
		wait_grants(2, 20);
		expect_grant(0, UNIT_AGEN, head_model, pl_old[7:0], t_rel + GRANT_LAT);
		expect_grant(1, UNIT_AGEN, head_model + 3'd1, pl_young[7:0], t_rel + GRANT_LAT + 1);
		idle_cycles(3);
		check("issue_count_o", cnt0 + 2, issue_count);
	endtask

	task automatic test_sync_barrier();
		logic [31:0] pl;
		logic [31:0] rd;
		rob_ndx_t    sync_ndx;
		int          t_wr;
		clear_window();
		sync_ndx = head_model;
		take_bits(`SCHED_PAYLOAD_W, pl);
		apb_write(entry_addr(sync_ndx), entry_word(1'b1, CLS_SYNC, 1'b1, 1'b1, 8'h00), 1'b0);
		apb_write(entry_addr(sync_ndx + 3'd1), entry_word(1'b1, CLS_ALU, 1'b1, 1'b1, pl[7:0]), 1'b0);
		idle_cycles(6);
		check("grants behind a sync", 0, grant_log.size());
		// Moving the head one step retires the sync entry
		apb_write(`SCHED_HEAD_ADDR, 32'(sync_ndx + 3'd1), 1'b0);
		head_model = sync_ndx + 3'd1;
		t_wr = neg_cnt;
		wait_grants(1, 20);
		expect_grant(0, UNIT_ALU0, head_model, pl[7:0], t_wr + GRANT_LAT);
		apb_read(`SCHED_HEAD_ADDR, rd);
		check("head register", 32'(head_model), rd);
		apb_read(entry_addr(sync_ndx), rd);
		check("retired entry valid", 0, rd[`SCHED_F_VALID]);
	endtask

	task automatic test_stomp();
		logic [31:0]  pl_a;
		logic [31:0]  pl_b;
		logic [31:0]  mask;
		logic [31:0]  rd;
		rob_ndx_t     ndx_a;
		rob_ndx_t     ndx_b;
		int           t_wr;
		issue_count_t cnt0;
		clear_window();
		cnt0  = issue_count;
		ndx_a = head_model + 3'd4;
		ndx_b = head_model + 3'd5;
		take_bits(`SCHED_PAYLOAD_W, pl_a);
		take_bits(`SCHED_PAYLOAD_W, pl_b);
		set_idle(1'b0);
		apb_write(entry_addr(ndx_a), entry_word(1'b1, CLS_ALU, 1'b1, 1'b1, pl_a[7:0]), 1'b0);
		apb_write(entry_addr(ndx_b), entry_word(1'b1, CLS_ALU, 1'b1, 1'b1, pl_b[7:0]), 1'b0);
		mask = '0;
		mask[ndx_a] = 1'b1;
		// Both picks fall in the stomp access cycle and only the unmasked one survives
		apb_write(`SCHED_STOMP_ADDR, mask, 1'b1);
		t_wr = neg_cnt;
		wait_grants(1, 10);
		idle_cycles(4);
		check("grant pulses", 1, grant_log.size());
		// The pick is made in the access cycle itself, one cycle ahead of a fresh write
		expect_grant(0, UNIT_ALU1, ndx_b, pl_b[7:0], t_wr + GRANT_LAT - 1);
		check("issue_count_o", cnt0 + 1, issue_count);
		apb_read(entry_addr(ndx_a), rd);
		check("stomped entry valid", 0, rd[`SCHED_F_VALID]);
	endtask

	// ==============================
	// Main sequence and watchdog
	// ==============================

	initial begin : main
		logic [31:0] rd;
		int          prop_fails;
		rst        = 1'b1;
		apb_req    = '0;
		set_idle(1'b1);
		lfsr       = 16'd31611;
		head_model = '0;
		n_checks   = 0;
		n_errors   = 0;
		repeat (2) @(posedge clk);
		#DRIVE;
		rst = 1'b0;
		check("alu0_grant_o.valid", 0, alu0_grant.valid);
		check("alu1_grant_o.valid", 0, alu1_grant.valid);
		check("agen_grant_o.valid", 0, agen_grant.valid);
		check("issue_count_o", 0, issue_count);
		apb_read(`SCHED_HEAD_ADDR, rd);
		check("head register", 0, rd);
		// Reset leaves the whole window empty
		for (int i = 0; i < `SCHED_ENTRIES; i++) begin
			apb_read(entry_addr(rob_ndx_t'(i)), rd);
			check($sformatf("entry %0d valid after reset", i), 0, rd[`SCHED_F_VALID]);
		end
		test_single_alu();
		test_oldest_first();
		test_mem_in_order();
		test_sync_barrier();
		test_stomp();
		prop_fails = u_dut.u_properties.fail_count;
		$display("checks %0d, check errors %0d, assertion failures %0d",
			n_checks, n_errors, prop_fails);
		if (n_errors == 0 && prop_fails == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#(NUM_TESTS * 200 * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
